// File: Bender.yml
package:
  name: i2c_subsystem

sources:
  - files:
      - design/i2c_pkg.sv
      - design/i2c_controller.sv
      - design/i2c_target.sv
      - design/i2c_bus_resolver.sv
      - design/i2c_subsystem.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_i2c_checker.sv
      - test/i2c_subsystem_assert.sv
      - test/tb_i2c_subsystem.sv

// File: design/i2c_bus_resolver.sv
`timescale 1ns/100ps

module i2c_bus_resolver #(
    parameter int NUM_TARGETS = i2c_pkg::NUM_TARGETS_DEF
) (
    input  logic                   i2c_clk,
    input  logic                   rst_n,
    input  logic                   scl_i,
    input  logic                   ctrl_sda_i,
    input  logic [NUM_TARGETS-1:0] tgt_sda_i,
    output logic                   sda_bus_o,
    output logic                   bus_busy_o
);

    logic sda_bus;
    logic scl_q;
    logic sda_q;
    logic bus_busy_q;
    logic start_det;
    logic stop_det;

    // Open drain, any single driver pulling low wins
    assign sda_bus = ctrl_sda_i & (&tgt_sda_i);

    // ==============================
    // START and STOP tracking
    // ==============================

    assign start_det = scl_i & scl_q & sda_q & ~sda_bus;
    assign stop_det  = scl_i & scl_q & ~sda_q & sda_bus;

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            bus_busy_q <= 1'b0;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_bus;
            if (start_det) begin
                bus_busy_q <= 1'b1;
            end else if (stop_det) begin
                bus_busy_q <= 1'b0;
            end
        end
    end

    assign sda_bus_o  = sda_bus;
    assign bus_busy_o = bus_busy_q;

endmodule

// File: design/i2c_controller.sv
`timescale 1ns/100ps

module i2c_controller (
    input  logic                        i2c_clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic [i2c_pkg::ADDR_W-1:0]  addr_i,
    input  logic                        rw_i,
    input  logic [i2c_pkg::DATA_W-1:0]  wdata_i,
    input  logic                        sda_i,
    output logic                        scl_o,
    output logic                        sda_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        nack_o,
    output logic [i2c_pkg::DATA_W-1:0]  rdata_o
);

    localparam int BIT_W = $clog2(i2c_pkg::DATA_W);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(i2c_pkg::DATA_W - 1);

    i2c_pkg::ctrl_state_t state_q;

    logic [i2c_pkg::PHASE_W-1:0] phase_q;
    logic [BIT_W-1:0]            bit_cnt_q;
    logic [i2c_pkg::DATA_W-1:0]  shift_q;
    logic [i2c_pkg::DATA_W-1:0]  wdata_q;
    logic [i2c_pkg::DATA_W-1:0]  rdata_q;
    logic                        rw_q;
    logic                        busy_q;
    logic                        done_q;
    logic                        nack_q;
    logic                        bit_end;
    logic                        cmd_accept;

    assign bit_end    = (phase_q == i2c_pkg::PHASE_SAMPLE);
    assign cmd_accept = (state_q == i2c_pkg::IDLE) && start_i;

    // ==============================
    // Sequencing FSM
    // ==============================

    // Each state lasts one or more whole bit slots, and moves on at the
    // end of the last phase of its slot
    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= i2c_pkg::IDLE;
            phase_q   <= '0;
            bit_cnt_q <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
            rdata_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (state_q == i2c_pkg::IDLE) begin
                phase_q   <= '0;
                bit_cnt_q <= '0;
                if (start_i) begin
                    state_q <= i2c_pkg::START;
                    busy_q  <= 1'b1;
                    nack_q  <= 1'b0;
                end
            end else begin
                phase_q <= bit_end ? '0 : phase_q + 1'b1;
                if (bit_end) begin
                    case (state_q)
                        i2c_pkg::START: begin
                            bit_cnt_q <= '0;
                            state_q   <= i2c_pkg::ADDR;
                        end
                        i2c_pkg::ADDR: begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == LAST_BIT) begin
                                state_q <= i2c_pkg::ADDR_ACK;
                            end
                        end
                        i2c_pkg::ADDR_ACK: begin
                            bit_cnt_q <= '0;
                            // A released line here means no target took the address
                            if (sda_i) begin
                                nack_q  <= 1'b1;
                                state_q <= i2c_pkg::STOP;
                            end else if (rw_q) begin
                                state_q <= i2c_pkg::RDATA;
                            end else begin
                                state_q <= i2c_pkg::WDATA;
                            end
                        end
                        i2c_pkg::WDATA: begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == LAST_BIT) begin
                                state_q <= i2c_pkg::WDATA_ACK;
                            end
                        end
                        i2c_pkg::WDATA_ACK: begin
                            state_q <= i2c_pkg::STOP;
                        end
                        i2c_pkg::RDATA: begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == LAST_BIT) begin
                                state_q <= i2c_pkg::RDATA_ACK;
                            end
                        end
                        i2c_pkg::RDATA_ACK: begin
                            rdata_q <= shift_q;
                            state_q <= i2c_pkg::STOP;
                        end
                        i2c_pkg::STOP: begin
                            busy_q  <= 1'b0;
                            done_q  <= 1'b1;
                            state_q <= i2c_pkg::IDLE;
                        end
                        default: begin
                            state_q <= i2c_pkg::IDLE;
                        end
                    endcase
                end
            end
        end
    end

    // Shift register, MSB first in both directions
    always_ff @(posedge i2c_clk) begin
        if (cmd_accept) begin
            shift_q <= {addr_i, rw_i};
            wdata_q <= wdata_i;
            rw_q    <= rw_i;
        end else if (bit_end) begin
            case (state_q)
                i2c_pkg::ADDR,
                i2c_pkg::WDATA:    shift_q <= {shift_q[i2c_pkg::DATA_W-2:0], 1'b0};
                i2c_pkg::ADDR_ACK: shift_q <= wdata_q;
                i2c_pkg::RDATA:    shift_q <= {shift_q[i2c_pkg::DATA_W-2:0], sda_i};
                default:           shift_q <= shift_q;
            endcase
        end
    end

    // ==============================
    // Bus pins
    // ==============================

    // START pulls SDA low halfway through a high SCL slot, STOP releases
    // it in the last phase while SCL is high
    always_comb begin
        scl_o = 1'b1;
        sda_o = 1'b1;
        case (state_q)
            i2c_pkg::IDLE: begin
                scl_o = 1'b1;
                sda_o = 1'b1;
            end
            i2c_pkg::START: begin
                scl_o = 1'b1;
                sda_o = (phase_q < i2c_pkg::PHASE_SCL_HIGH);
            end
            i2c_pkg::ADDR,
            i2c_pkg::WDATA: begin
                scl_o = (phase_q >= i2c_pkg::PHASE_SCL_HIGH);
                sda_o = shift_q[i2c_pkg::DATA_W-1];
            end
            i2c_pkg::STOP: begin
                scl_o = (phase_q >= i2c_pkg::PHASE_SCL_HIGH);
                sda_o = (phase_q == i2c_pkg::PHASE_SAMPLE);
            end
            default: begin
                // ACK slots and read data, the read ACK slot sends a NACK
                scl_o = (phase_q >= i2c_pkg::PHASE_SCL_HIGH);
                sda_o = 1'b1;
            end
        endcase
    end

    assign busy_o  = busy_q;
    assign done_o  = done_q;
    assign nack_o  = nack_q;
    assign rdata_o = rdata_q;

endmodule

// File: design/i2c_pkg.sv
package i2c_pkg;

    // ==============================
    // Bus widths
    // ==============================

    localparam int ADDR_W = 7;
    localparam int DATA_W = 8;

    // ==============================
    // Bit phases
    // ==============================

    // Every bus bit spans four i2c_clk cycles
    // Phases 0 and 1 keep SCL low, and SDA is set in phase 0
    // Phases 2 and 3 keep SCL high, and the controller samples in phase 3
    localparam int PHASES_PER_BIT = 4;
    localparam int PHASE_W = $clog2(PHASES_PER_BIT);

    localparam logic [PHASE_W-1:0] PHASE_SCL_HIGH = PHASE_W'(2);
    localparam logic [PHASE_W-1:0] PHASE_SAMPLE   = PHASE_W'(PHASES_PER_BIT - 1);

    // Default bus population, target k answers BASE_ADDR_DEF + k
    localparam int                 NUM_TARGETS_DEF = 4;
    localparam logic [ADDR_W-1:0]  BASE_ADDR_DEF   = 7'h20;

    // Controller FSM states
    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        WDATA,
        WDATA_ACK,
        RDATA,
        RDATA_ACK,
        STOP
    } ctrl_state_t;

endpackage

// File: design/i2c_subsystem.sv
`timescale 1ns/100ps

module i2c_subsystem #(
    parameter int                         NUM_TARGETS = i2c_pkg::NUM_TARGETS_DEF,
    parameter logic [i2c_pkg::ADDR_W-1:0] BASE_ADDR   = i2c_pkg::BASE_ADDR_DEF
) (
    input  logic                                    i2c_clk,
    input  logic                                    rst_n,
    input  logic                                    start_i,
    input  logic [i2c_pkg::ADDR_W-1:0]              addr_i,
    input  logic                                    rw_i,
    input  logic [i2c_pkg::DATA_W-1:0]              wdata_i,
    output logic                                    busy_o,
    output logic                                    done_o,
    output logic                                    nack_o,
    output logic [i2c_pkg::DATA_W-1:0]              rdata_o,
    output logic                                    bus_busy_o,
    output logic                                    scl_o,
    output logic                                    sda_o,
    output logic [NUM_TARGETS*i2c_pkg::DATA_W-1:0]  target_data_o
);

    logic                   scl;
    logic                   ctrl_sda;
    logic                   sda_bus;
    logic [NUM_TARGETS-1:0] tgt_sda;

    i2c_controller u_controller (
        .i2c_clk (i2c_clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .addr_i  (addr_i),
        .rw_i    (rw_i),
        .wdata_i (wdata_i),
        .sda_i   (sda_bus),
        .scl_o   (scl),
        .sda_o   (ctrl_sda),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .nack_o  (nack_o),
        .rdata_o (rdata_o)
    );

    // Targets sit on consecutive addresses starting at BASE_ADDR
    for (genvar k = 0; k < NUM_TARGETS; k++) begin : g_target
        localparam int unsigned TGT_ADDR = int'(BASE_ADDR) + k;

        i2c_target #(
            .TARGET_ADDR (TGT_ADDR[i2c_pkg::ADDR_W-1:0])
        ) u_target (
            .i2c_clk (i2c_clk),
            .rst_n   (rst_n),
            .scl_i   (scl),
            .sda_i   (sda_bus),
            .sda_o   (tgt_sda[k]),
            .data_o  (target_data_o[k*i2c_pkg::DATA_W +: i2c_pkg::DATA_W])
        );
    end

    i2c_bus_resolver #(
        .NUM_TARGETS (NUM_TARGETS)
    ) u_resolver (
        .i2c_clk    (i2c_clk),
        .rst_n      (rst_n),
        .scl_i      (scl),
        .ctrl_sda_i (ctrl_sda),
        .tgt_sda_i  (tgt_sda),
        .sda_bus_o  (sda_bus),
        .bus_busy_o (bus_busy_o)
    );

    assign scl_o = scl;
    assign sda_o = sda_bus;

endmodule

// File: design/i2c_target.sv
`timescale 1ns/100ps

module i2c_target #(
    parameter logic [i2c_pkg::ADDR_W-1:0] TARGET_ADDR = i2c_pkg::BASE_ADDR_DEF
) (
    input  logic                        i2c_clk,
    input  logic                        rst_n,
    input  logic                        scl_i,
    input  logic                        sda_i,
    output logic                        sda_o,
    output logic [i2c_pkg::DATA_W-1:0]  data_o
);

    localparam int BCNT_W = $clog2(i2c_pkg::DATA_W + 1);
    localparam logic [BCNT_W-1:0] BYTE_BITS = BCNT_W'(i2c_pkg::DATA_W);

    typedef enum logic [2:0] {
        T_IDLE,
        T_ADDR,
        T_ADDR_ACK,
        T_WRITE,
        T_WRITE_ACK,
        T_READ
    } tgt_state_t;

    tgt_state_t state_q;

    logic                       scl_q;
    logic                       sda_q;
    logic [BCNT_W-1:0]          bit_cnt_q;
    logic [i2c_pkg::DATA_W-1:0] shift_q;
    logic [i2c_pkg::DATA_W-1:0] data_q;
    logic                       rw_q;
    logic                       sda_drv_q;
    logic                       scl_rise;
    logic                       scl_fall;
    logic                       start_det;
    logic                       stop_det;

    // ==============================
    // Bus event detection
    // ==============================

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;
        end
    end

    assign scl_rise  = scl_i & ~scl_q;
    assign scl_fall  = ~scl_i & scl_q;
    assign start_det = scl_i & scl_q & sda_q & ~sda_i;
    assign stop_det  = scl_i & scl_q & ~sda_q & sda_i;

    // ==============================
    // Byte engine
    // ==============================

    // Data is taken on SCL rise, and every drive change waits for SCL fall
    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= T_IDLE;
            bit_cnt_q <= '0;
            shift_q   <= '0;
            data_q    <= '0;
            rw_q      <= 1'b0;
            sda_drv_q <= 1'b1;
        end else if (start_det) begin
            state_q   <= T_ADDR;
            bit_cnt_q <= '0;
            sda_drv_q <= 1'b1;
        end else if (stop_det) begin
            state_q   <= T_IDLE;
            sda_drv_q <= 1'b1;
        end else begin
            case (state_q)
                T_ADDR,
                T_WRITE: begin
                    if (scl_rise) begin
                        shift_q   <= {shift_q[i2c_pkg::DATA_W-2:0], sda_i};
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end else if (scl_fall && (bit_cnt_q == BYTE_BITS)) begin
                        bit_cnt_q <= '0;
                        if (state_q == T_WRITE) begin
                            data_q    <= shift_q;
                            sda_drv_q <= 1'b0;
                            state_q   <= T_WRITE_ACK;
                        end else if (shift_q[i2c_pkg::DATA_W-1:1] == TARGET_ADDR) begin
                            rw_q      <= shift_q[0];
                            sda_drv_q <= 1'b0;
                            state_q   <= T_ADDR_ACK;
                        end else begin
                            // Someone else's address, wait for the next START
                            state_q <= T_IDLE;
                        end
                    end
                end
                T_ADDR_ACK: begin
                    if (scl_fall) begin
                        if (rw_q) begin
                            sda_drv_q <= data_q[i2c_pkg::DATA_W-1];
                            shift_q   <= {data_q[i2c_pkg::DATA_W-2:0], 1'b0};
                            state_q   <= T_READ;
                        end else begin
                            sda_drv_q <= 1'b1;
                            state_q   <= T_WRITE;
                        end
                    end
                end
                T_WRITE_ACK: begin
                    if (scl_fall) begin
                        sda_drv_q <= 1'b1;
                        state_q   <= T_IDLE;
                    end
                end
                T_READ: begin
                    if (scl_rise) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end else if (scl_fall) begin
                        if (bit_cnt_q == BYTE_BITS) begin
                            // Let go for the controller's ACK slot
                            sda_drv_q <= 1'b1;
                            state_q   <= T_IDLE;
                        end else begin
                            sda_drv_q <= shift_q[i2c_pkg::DATA_W-1];
                            shift_q   <= {shift_q[i2c_pkg::DATA_W-2:0], 1'b0};
                        end
                    end
                end
                default: begin
                    sda_drv_q <= 1'b1;
                end
            endcase
        end
    end

    assign sda_o  = sda_drv_q;
    assign data_o = data_q;

endmodule

// File: i2c_subsystem.f
design/i2c_pkg.sv
design/i2c_controller.sv
design/i2c_target.sv
design/i2c_bus_resolver.sv
design/i2c_subsystem.sv
test/tb_clock_gen.sv
test/tb_i2c_checker.sv
test/i2c_subsystem_assert.sv
test/tb_i2c_subsystem.sv

// File: test/i2c_subsystem_assert.sv
`timescale 1ns/100ps

module i2c_subsystem_assert (
    input logic i2c_clk_i,
    input logic rst_n_i,
    input logic scl_i,
    input logic sda_i,
    input logic done_i,
    input logic busy_i,
    input logic nack_i,
    input logic bus_busy_i
);

    int fail_count = 0;

    // SDA falling under a high SCL is a START, and that is only legal on an idle bus
    a_start_on_idle: assert property (@(posedge i2c_clk_i) disable iff (!rst_n_i)
        (scl_i && $past(scl_i) && $fell(sda_i)) |-> !bus_busy_i)
        else begin
            fail_count++;
            $error("SDA fell under a high SCL while the bus was busy");
        end

    // SDA rising under a high SCL is a STOP, and that only closes an open transfer
    a_stop_on_busy: assert property (@(posedge i2c_clk_i) disable iff (!rst_n_i)
        (scl_i && $past(scl_i) && $rose(sda_i)) |-> bus_busy_i)
        else begin
            fail_count++;
            $error("SDA rose under a high SCL while the bus was idle");
        end

    a_done_pulse: assert property (@(posedge i2c_clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else begin
            fail_count++;
            $error("done_o stayed high for more than one cycle");
        end

    a_reset_state: assert property (@(posedge i2c_clk_i)
        $rose(rst_n_i) |-> (!done_i && !busy_i && !nack_i && !bus_busy_i && scl_i && sda_i))
        else begin
            fail_count++;
            $error("Outputs were not idle when reset was released");
        end

endmodule

bind i2c_subsystem i2c_subsystem_assert u_assert (
    .i2c_clk_i  (i2c_clk),
    .rst_n_i    (rst_n),
    .scl_i      (scl_o),
    .sda_i      (sda_o),
    .done_i     (done_o),
    .busy_i     (busy_o),
    .nack_i     (nack_o),
    .bus_busy_i (bus_busy_o)
);

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic i2c_clk_o,
    output logic rst_n_o
);

    initial begin
        i2c_clk_o = 1'b0;
        forever #(PERIOD_NS / 2) i2c_clk_o = ~i2c_clk_o;
    end

    // Reset leaves on a rising edge, so the DUT sees it low on that edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge i2c_clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: test/tb_i2c_checker.sv
`timescale 1ns/100ps

module tb_i2c_checker #(
    parameter int NUM_TARGETS = i2c_pkg::NUM_TARGETS_DEF
) (
    input  logic                                    i2c_clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    start_i,
    input  logic                                    busy_i,
    input  logic                                    done_i,
    input  logic                                    nack_i,
    input  logic [i2c_pkg::DATA_W-1:0]              rdata_i,
    input  logic                                    bus_busy_i,
    input  logic [NUM_TARGETS*i2c_pkg::DATA_W-1:0]  target_data_i,
    input  logic                                    exp_valid_i,
    input  logic                                    exp_rw_i,
    input  logic                                    exp_nack_i,
    input  logic [i2c_pkg::DATA_W-1:0]              exp_rdata_i,
    input  int                                      exp_latency_i,
    input  logic [NUM_TARGETS*i2c_pkg::DATA_W-1:0]  exp_targets_i,
    output int                                      check_count_o,
    output int                                      error_count_o
);

    localparam int DW = i2c_pkg::DATA_W;

    // The START condition needs a few cycles before the bus tracker sees it
    localparam int BUS_SETTLE = 5;

    int                                  check_count_q = 0;
    int                                  error_count_q = 0;
    int                                  cycle_q = 0;
    int                                  start_cycle_q = 0;
    int                                  latency;
    logic                                pending_q = 1'b0;
    logic                                pend_rw_q;
    logic                                pend_nack_q;
    logic [DW-1:0]                       pend_rdata_q;
    int                                  pend_latency_q;
    logic [NUM_TARGETS*DW-1:0]           pend_targets_q;

    task automatic check_value(input string what, input int got, input int expected);
        check_count_q++;
        if (got != expected) begin
            error_count_q++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic flag_problem(input string what);
        error_count_q++;
        $display("Problem at %0t: %s", $time, what);
    endtask

    // ==============================
    // Sampling on the rising edge
    // ==============================

    always @(posedge i2c_clk_i) begin
        if (rst_n_i) begin
            if (done_i) begin
                if (!pending_q) begin
                    flag_problem("done_o pulsed with no command outstanding");
                end else begin
                    // done_o rose on the previous edge
                    latency = cycle_q - 1 - start_cycle_q;
                    check_value("done latency", latency, pend_latency_q);
                    check_value("nack_o", nack_i, pend_nack_q);
                    if (pend_rw_q && !pend_nack_q) begin
                        check_value("rdata_o", rdata_i, pend_rdata_q);
                    end
                    for (int k = 0; k < NUM_TARGETS; k++) begin
                        check_value($sformatf("target %0d data", k),
                                    target_data_i[k*DW +: DW], pend_targets_q[k*DW +: DW]);
                    end
                    check_value("busy_o at done", busy_i, 0);
                    check_value("bus_busy_o at done", bus_busy_i, 0);
                    pending_q = 1'b0;
                end
            end else if (pending_q) begin
                if (!busy_i) begin
                    flag_problem("busy_o dropped while a transaction was running");
                end
                if ((cycle_q - start_cycle_q >= BUS_SETTLE) && !bus_busy_i) begin
                    flag_problem("bus_busy_o low in the middle of a transaction");
                end
            end else if (bus_busy_i) begin
                flag_problem("bus_busy_o high while the bus is idle");
            end

            if (start_i && !busy_i) begin
                start_cycle_q = cycle_q;
                if (!exp_valid_i) begin
                    flag_problem("a command was taken that the testbench did not send");
                end
            end

            if (exp_valid_i) begin
                if (pending_q) begin
                    flag_problem("a new command was sent before the last one finished");
                end
                if (!(start_i && !busy_i)) begin
                    flag_problem("a command sent while idle was not taken");
                end
                pending_q      = 1'b1;
                pend_rw_q      = exp_rw_i;
                pend_nack_q    = exp_nack_i;
                pend_rdata_q   = exp_rdata_i;
                pend_latency_q = exp_latency_i;
                pend_targets_q = exp_targets_i;
            end
            cycle_q++;
        end
    end

    assign check_count_o = check_count_q;
    assign error_count_o = error_count_q;

endmodule

// File: test/tb_i2c_subsystem.sv
`timescale 1ns/100ps

module tb_i2c_subsystem;

    localparam int                         NUM_TARGETS = i2c_pkg::NUM_TARGETS_DEF;
    localparam logic [i2c_pkg::ADDR_W-1:0] BASE_ADDR   = i2c_pkg::BASE_ADDR_DEF;
    localparam int                         DW          = i2c_pkg::DATA_W;
    localparam int                         AW          = i2c_pkg::ADDR_W;
    localparam int                         NUM_RANDOM  = 30;
    localparam int                         MAX_CYCLES  = 40 * 90 + 200;

    logic                      i2c_clk;
    logic                      rst_n;
    logic                      start;
    logic [AW-1:0]             addr;
    logic                      rw;
    logic [DW-1:0]             wdata;
    logic                      busy;
    logic                      done;
    logic                      nack;
    logic [DW-1:0]             rdata;
    logic                      bus_busy;
    logic                      scl;
    logic                      sda;
    logic [NUM_TARGETS*DW-1:0] target_data;

    logic                      exp_valid;
    logic                      exp_rw;
    logic                      exp_nack;
    logic [DW-1:0]             exp_rdata;
    int                        exp_latency;
    logic [NUM_TARGETS*DW-1:0] exp_targets;
    int                        check_count;
    int                        error_count;

    logic [15:0]               lfsr_q;
    logic [DW-1:0]             shadow [NUM_TARGETS];

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(4)) u_clock_gen (
        .i2c_clk_o (i2c_clk),
        .rst_n_o   (rst_n)
    );

    i2c_subsystem u_dut (
        .i2c_clk (i2c_clk), .rst_n (rst_n), .start_i (start), .addr_i (addr),
        .rw_i (rw), .wdata_i (wdata), .busy_o (busy), .done_o (done),
        .nack_o (nack), .rdata_o (rdata), .bus_busy_o (bus_busy), .scl_o (scl),
        .sda_o (sda), .target_data_o (target_data)
    );

    tb_i2c_checker #(.NUM_TARGETS(NUM_TARGETS)) u_checker (
        .i2c_clk_i (i2c_clk), .rst_n_i (rst_n), .start_i (start), .busy_i (busy),
        .done_i (done), .nack_i (nack), .rdata_i (rdata), .bus_busy_i (bus_busy),
        .target_data_i (target_data), .exp_valid_i (exp_valid), .exp_rw_i (exp_rw),
        .exp_nack_i (exp_nack), .exp_rdata_i (exp_rdata), .exp_latency_i (exp_latency),
        .exp_targets_i (exp_targets), .check_count_o (check_count),
        .error_count_o (error_count)
    );

    // ==============================
    // Reference model
    // ==============================

    // START, address byte with ACK, optional data byte with ACK, then STOP
    function automatic void predict_cmd(input logic [AW-1:0] a, input logic r,
                                        input logic [DW-1:0] d, output logic n,
                                        output logic [DW-1:0] q, output int lat);
        int idx;
        idx = int'(a) - int'(BASE_ADDR);
        n   = (idx < 0) || (idx >= NUM_TARGETS);
        q   = '0;
        lat = (2 + (n ? 9 : 18)) * i2c_pkg::PHASES_PER_BIT;
        if (!n) begin
            if (r) begin
                q = shadow[idx];
            end else begin
                shadow[idx] = d;
            end
        end
    endfunction

    function automatic logic [NUM_TARGETS*DW-1:0] shadow_image();
        logic [NUM_TARGETS*DW-1:0] img;
        for (int k = 0; k < NUM_TARGETS; k++) begin
            img[k*DW +: DW] = shadow[k];
        end
        return img;
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [DW-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[DW-2:0], lfsr_q[0]};
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================

    task automatic issue_cmd(input logic [AW-1:0] a, input logic r, input logic [DW-1:0] d);
        logic          n;
        logic [DW-1:0] q;
        int            lat;
        @(posedge i2c_clk);
        predict_cmd(a, r, d, n, q, lat);
        start       <= 1'b1;
        addr        <= a;
        rw          <= r;
        wdata       <= d;
        exp_valid   <= 1'b1;
        exp_rw      <= r;
        exp_nack    <= n;
        exp_rdata   <= q;
        exp_latency <= lat;
        exp_targets <= shadow_image();
        @(posedge i2c_clk);
        start     <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    task automatic wait_done();
        while (!done) @(posedge i2c_clk);
    endtask

    task automatic run_cmd(input logic [AW-1:0] a, input logic r, input logic [DW-1:0] d);
        issue_cmd(a, r, d);
        wait_done();
    endtask

    initial begin
        logic [DW-1:0] idx_bits;
        logic [DW-1:0] rw_bits;
        logic [DW-1:0] data_bits;
        start       = 1'b0;
        addr        = '0;
        rw          = 1'b0;
        wdata       = '0;
        exp_valid   = 1'b0;
        exp_rw      = 1'b0;
        exp_nack    = 1'b0;
        exp_rdata   = '0;
        exp_latency = 0;
        exp_targets = '0;
        lfsr_q      = 16'd99;
        for (int k = 0; k < NUM_TARGETS; k++) begin
            shadow[k] = '0;
        end
        wait (rst_n === 1'b1);
        @(posedge i2c_clk);

        // First write also gets a second start pulse while busy, which must vanish
        issue_cmd(BASE_ADDR, 1'b0, 8'h5A);
        repeat (10) @(posedge i2c_clk);
        start <= 1'b1;
        addr  <= BASE_ADDR + 7'd1;
        rw    <= 1'b0;
        wdata <= 8'hEE;
        @(posedge i2c_clk);
        start <= 1'b0;
        wait_done();

        for (int k = 1; k < NUM_TARGETS; k++) begin
            run_cmd(BASE_ADDR + AW'(k), 1'b0, 8'h5A + DW'(k * 8'h31));
        end
        for (int k = 0; k < NUM_TARGETS; k++) begin
            run_cmd(BASE_ADDR + AW'(k), 1'b1, 8'h00);
        end

        // Addresses just above and well below the target range
        run_cmd(BASE_ADDR + AW'(NUM_TARGETS), 1'b0, 8'hC3);
        run_cmd(7'h10, 1'b1, 8'h00);

        // Index 4 to 7 lands outside the range and gets a NACK
        repeat (NUM_RANDOM) begin
            draw_bits(3, idx_bits);
            draw_bits(1, rw_bits);
            draw_bits(DW, data_bits);
            run_cmd(BASE_ADDR + AW'(idx_bits[2:0]), rw_bits[0], data_bits);
        end
        repeat (4) @(posedge i2c_clk);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, u_dut.u_assert.fail_count);
        if ((error_count == 0) && (u_dut.u_assert.fail_count == 0) && (check_count > 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge i2c_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule
